/* daq_capture_pkg.sv */
package daq_capture_pkg;

	////////////////////////////////////////////////////////////
	// Sample side
	////////////////////////////////////////////////////////////

	// One receiver word is one sample
	localparam int SAMPLE_W = 16;

	// Free timestamp counter width
	localparam int TS_W = 16;

	////////////////////////////////////////////////////////////
	// Beat layout
	////////////////////////////////////////////////////////////

	// Samples packed per memory beat
	localparam int WORDS_PER_BEAT = 16;

	// Full beat width on the memory bus
	localparam int BEAT_W = SAMPLE_W * WORDS_PER_BEAT;  // 256 bits

	// Slot index inside a beat
	// Slot 0 holds the first sample in bits [15:0] and later slots fill upward
	localparam int SLOT_W = $clog2(WORDS_PER_BEAT);

	////////////////////////////////////////////////////////////
	// Memory side
	////////////////////////////////////////////////////////////

	localparam int ADDR_W = 25;   // Beat address
	localparam int BURST_W = 5;   // Avalon burstcount field

endpackage

/* sample_front_end.sv */
`timescale 1ns/1ns

module sample_front_end #(
	parameter int NUM_CH = 4
) (
	input  logic avalon_clk,
	input  logic rst_n,

	// Receiver lanes, lane 0 in the low word
	input  logic [NUM_CH*daq_capture_pkg::SAMPLE_W-1:0] rx_data,
	input  logic [NUM_CH-1:0] rx_datak,        // Control word flag
	input  logic [NUM_CH-1:0] rx_syncstatus,   // Word alignment locked
	input  logic [daq_capture_pkg::SAMPLE_W-1:0] threshold,

	// To the reorder buffers
	output logic [NUM_CH-1:0] sample_valid,
	output logic [NUM_CH*daq_capture_pkg::SAMPLE_W-1:0] sample_data,

	// Trigger result
	output logic triggering_status,
	output logic [daq_capture_pkg::TS_W-1:0] triggering_time_stamp
);

	localparam int SW = daq_capture_pkg::SAMPLE_W;

	logic [daq_capture_pkg::TS_W-1:0] ts_cnt;   // Free timestamp
	logic [NUM_CH-1:0] accept;                 // Data word on a synced lane
	logic [NUM_CH-1:0] hit;                    // Accepted and above threshold

	////////////////////////////////////////////////////////////
	// Word filter and threshold compare
	////////////////////////////////////////////////////////////

	always_comb begin
		for (int c = 0; c < NUM_CH; c++) begin
			accept[c] = rx_syncstatus[c] & ~rx_datak[c];   // Drop K words and unsynced
			hit[c] = accept[c] && (rx_data[c*SW +: SW] > threshold);   // Unsigned compare
		end
	end

	// Timestamp runs from 0 right after reset release
	always_ff @(posedge avalon_clk) begin
		if (!rst_n) begin
			ts_cnt <= '0;
		end else begin
			ts_cnt <= ts_cnt + 1'b1;   // Wraps
		end
	end

	////////////////////////////////////////////////////////////
	// Sample registers
	////////////////////////////////////////////////////////////

	// One strobe per accepted word
	always_ff @(posedge avalon_clk) begin
		if (!rst_n) begin
			sample_valid <= '0;
		end else begin
			sample_valid <= accept;
		end
	end

	// Data word only loads on acceptance
	always_ff @(posedge avalon_clk) begin
		for (int c = 0; c < NUM_CH; c++) begin
			if (accept[c]) begin
				sample_data[c*SW +: SW] <= rx_data[c*SW +: SW];
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Trigger latch
	////////////////////////////////////////////////////////////

	// First hit wins and holds until reset
	always_ff @(posedge avalon_clk) begin
		if (!rst_n) begin
			triggering_status <= 1'b0;
			triggering_time_stamp <= '0;
		end else if (!triggering_status && (|hit)) begin
			triggering_status <= 1'b1;
			triggering_time_stamp <= ts_cnt;   // Count at the acceptance edge
		end
	end

	// Sticky once set
	trig_sticky_a: assert property (@(posedge avalon_clk) disable iff (!rst_n)
		triggering_status |=> triggering_status);

endmodule

/* channel_reorder_buffer.sv */
`timescale 1ns/1ns

module channel_reorder_buffer #(
	parameter int BURST_LEN = 4,
	parameter int FIFO_DEPTH = 8
) (
	input  logic avalon_clk,
	input  logic rst_n,

	// From the front end
	input  logic sample_valid,
	input  logic [daq_capture_pkg::SAMPLE_W-1:0] sample_data,

	// Scheduler side
	input  logic beat_pop,                                  // Drop head beat
	output logic beat_ready,                                // A full burst waits
	output logic [daq_capture_pkg::BEAT_W-1:0] head_data    // Oldest beat
);

	localparam int SW = daq_capture_pkg::SAMPLE_W;
	localparam int BW = daq_capture_pkg::BEAT_W;
	localparam int SLOT_W = daq_capture_pkg::SLOT_W;
	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	logic [BW-1:0] beat_mem [FIFO_DEPTH];   // Beat queue
	logic [BW-1:0] asm_beat;                // Assembly shift register
	logic [BW-1:0] next_beat;
	logic [SLOT_W-1:0] slot_cnt;            // Samples held in asm_beat
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] fill_cnt;             // Beats queued
	logic beat_done;
	logic full;
	logic push;

	// Pointer step with wrap for any depth
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		logic [PTR_W-1:0] nxt;
		if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
			nxt = '0;
		end else begin
			nxt = ptr + 1'b1;
		end
		return nxt;
	endfunction

	////////////////////////////////////////////////////////////
	// Beat assembly
	////////////////////////////////////////////////////////////

	// New sample enters at the top so the first one ends in slot 0
	assign next_beat = {sample_data, asm_beat[BW-1:SW]};
	assign beat_done = sample_valid &&
		(slot_cnt == SLOT_W'(daq_capture_pkg::WORDS_PER_BEAT - 1));
	assign full = (fill_cnt == CNT_W'(FIFO_DEPTH));
	assign push = beat_done && !full;   // Overflow beats are lost

	always_ff @(posedge avalon_clk) begin
		if (sample_valid) begin
			asm_beat <= next_beat;
		end
	end

	always_ff @(posedge avalon_clk) begin
		if (!rst_n) begin
			slot_cnt <= '0;
		end else if (beat_done) begin
			slot_cnt <= '0;
		end else if (sample_valid) begin
			slot_cnt <= slot_cnt + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Beat queue
	////////////////////////////////////////////////////////////

	always_ff @(posedge avalon_clk) begin
		if (push) begin
			beat_mem[wr_ptr] <= next_beat;   // Completed beat
		end
	end

	always_ff @(posedge avalon_clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill_cnt <= '0;
		end else begin
			if (push) wr_ptr <= ptr_inc(wr_ptr);
			if (beat_pop) rd_ptr <= ptr_inc(rd_ptr);
			case ({push, beat_pop})
				2'b10: fill_cnt <= fill_cnt + 1'b1;
				2'b01: fill_cnt <= fill_cnt - 1'b1;
				default: fill_cnt <= fill_cnt;   // Idle or both
			endcase
		end
	end

	assign head_data = beat_mem[rd_ptr];                     // Shown ahead of pop
	assign beat_ready = (fill_cnt >= CNT_W'(BURST_LEN));     // Level

	// Scheduler only pops what it saw queued
	pop_not_empty_a: assert property (@(posedge avalon_clk) disable iff (!rst_n)
		beat_pop |-> (fill_cnt != '0));

endmodule

/* dram_write_scheduler.sv */
`timescale 1ns/1ns

module dram_write_scheduler #(
	parameter int NUM_CH = 4,
	parameter int BURST_LEN = 4,
	parameter int REGION_BITS = 20,
	parameter int POST_TRIGGER_BURSTS = 2
) (
	input  logic avalon_clk,
	input  logic rst_n,

	// Buffer side
	input  logic [NUM_CH-1:0] beat_ready,
	input  logic [NUM_CH*daq_capture_pkg::BEAT_W-1:0] head_data,
	output logic [NUM_CH-1:0] beat_pop,

	input  logic triggering_status,

	// Avalon write master
	input  logic dram_waitrequest_n,
	output logic dram_write,
	output logic dram_burst_begin,
	output logic [daq_capture_pkg::BURST_W-1:0] dram_burst_count,
	output logic [daq_capture_pkg::ADDR_W-1:0] dram_address,
	output logic [daq_capture_pkg::BEAT_W-1:0] dram_writedata,

	output logic [NUM_CH-1:0] capture_mask   // Channel stopped
);

	localparam int BW = daq_capture_pkg::BEAT_W;
	localparam int AW = daq_capture_pkg::ADDR_W;
	localparam int CH_W = (NUM_CH > 1) ? $clog2(NUM_CH) : 1;
	localparam int BEAT_CNT_W = (BURST_LEN > 1) ? $clog2(BURST_LEN) : 1;
	localparam int PCNT_W = (POST_TRIGGER_BURSTS > 0) ? $clog2(POST_TRIGGER_BURSTS + 1) : 1;

	typedef enum logic {
		ST_IDLE,
		ST_BURST
	} state_t;

	state_t state;
	logic [NUM_CH-1:0] req;               // Ready and still capturing
	logic grant_valid;
	logic [CH_W-1:0] grant_ch;
	logic [CH_W-1:0] sel_ch;              // Channel in the current burst
	logic [CH_W-1:0] last_ch;             // Round robin pointer
	logic [BEAT_CNT_W-1:0] beat_cnt;      // Beats accepted in burst
	logic [REGION_BITS-1:0] offset [NUM_CH];
	logic [PCNT_W-1:0] post_cnt [NUM_CH];
	logic burst_post;                     // Burst began after trigger
	logic post_now;
	logic beat_taken;
	logic last_beat;

	// Region base plus running beat offset
	function automatic logic [AW-1:0] burst_addr(input logic [CH_W-1:0] ch,
			input logic [REGION_BITS-1:0] ofs);
		logic [AW-1:0] base;
		base = AW'(ch) << REGION_BITS;
		return base + AW'(ofs);
	endfunction

	////////////////////////////////////////////////////////////
	// Round robin arbiter
	////////////////////////////////////////////////////////////

	assign req = beat_ready & ~capture_mask;

	// Search starts one past the channel last served
	always_comb begin
		int idx;
		grant_valid = 1'b0;
		grant_ch = last_ch;
		for (int i = 1; i <= NUM_CH; i++) begin
			idx = (int'(last_ch) + i) % NUM_CH;
			if (!grant_valid && req[idx]) begin
				grant_valid = 1'b1;
				grant_ch = CH_W'(idx);
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Beat stream
	////////////////////////////////////////////////////////////

	assign beat_taken = dram_write && dram_waitrequest_n;   // Slave took the beat
	assign last_beat = (beat_cnt == BEAT_CNT_W'(BURST_LEN - 1));
	assign post_now = dram_burst_begin ? triggering_status : burst_post;

	// Head beat goes straight out and stays put until popped
	assign dram_writedata = head_data[sel_ch*BW +: BW];

	always_comb begin
		beat_pop = '0;
		beat_pop[sel_ch] = beat_taken;   // Pop exactly the accepted beat
	end

	always_ff @(posedge avalon_clk) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			dram_write <= 1'b0;
			dram_burst_begin <= 1'b0;
			dram_burst_count <= '0;
			dram_address <= '0;
			sel_ch <= '0;
			last_ch <= CH_W'(NUM_CH - 1);   // Channel 0 goes first
			beat_cnt <= '0;
			burst_post <= 1'b0;
			capture_mask <= '0;
			for (int c = 0; c < NUM_CH; c++) begin
				offset[c] <= '0;   // Region base
				post_cnt[c] <= '0;
			end
		end else begin
			case (state)
				ST_IDLE: begin
					if (grant_valid) begin
						state <= ST_BURST;
						sel_ch <= grant_ch;
						last_ch <= grant_ch;
						dram_write <= 1'b1;
						dram_burst_begin <= 1'b1;
						dram_burst_count <= daq_capture_pkg::BURST_W'(BURST_LEN);
						dram_address <= burst_addr(grant_ch, offset[grant_ch]);
						beat_cnt <= '0;
					end
				end
				ST_BURST: begin
					if (beat_taken) begin
						dram_burst_begin <= 1'b0;   // First beat only
						dram_burst_count <= '0;
						burst_post <= post_now;
						beat_cnt <= beat_cnt + 1'b1;
						if (last_beat) begin
							state <= ST_IDLE;   // One idle cycle before next grant
							dram_write <= 1'b0;
							offset[sel_ch] <= offset[sel_ch] + REGION_BITS'(BURST_LEN);
							if (post_now) begin
								post_cnt[sel_ch] <= post_cnt[sel_ch] + 1'b1;
								// Last allowed post-trigger burst done
								if (post_cnt[sel_ch] == PCNT_W'(POST_TRIGGER_BURSTS - 1))
									capture_mask[sel_ch] <= 1'b1;
							end
						end
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Pending beat frozen while slave stalls
	hold_under_wait_a: assert property (@(posedge avalon_clk) disable iff (!rst_n)
		(dram_write && !dram_waitrequest_n) |=>
			(dram_write && $stable(dram_address) && $stable(dram_writedata) &&
			$stable(dram_burst_begin)));

endmodule

/* daq_capture_top.sv */
`timescale 1ns/1ns

module daq_capture_top #(
	parameter int NUM_CH = 4,
	parameter int BURST_LEN = 4,              // Beats per burst
	parameter int FIFO_DEPTH = 8,             // Beats per channel buffer
	parameter int REGION_BITS = 20,           // Beat offset range per channel
	parameter int POST_TRIGGER_BURSTS = 2
) (
	input  logic avalon_clk,
	input  logic rst_n,

	// Receiver lanes
	input  logic [NUM_CH*daq_capture_pkg::SAMPLE_W-1:0] rx_data,
	input  logic [NUM_CH-1:0] rx_datak,
	input  logic [NUM_CH-1:0] rx_syncstatus,
	input  logic [daq_capture_pkg::SAMPLE_W-1:0] threshold,

	// Memory write port
	input  logic dram_waitrequest_n,
	output logic dram_write,
	output logic dram_burst_begin,
	output logic [daq_capture_pkg::BURST_W-1:0] dram_burst_count,
	output logic [daq_capture_pkg::ADDR_W-1:0] dram_address,
	output logic [daq_capture_pkg::BEAT_W-1:0] dram_writedata,

	// Status
	output logic triggering_status,
	output logic [daq_capture_pkg::TS_W-1:0] triggering_time_stamp,
	output logic [NUM_CH-1:0] capture_mask
);

	localparam int SW = daq_capture_pkg::SAMPLE_W;
	localparam int BW = daq_capture_pkg::BEAT_W;

	logic [NUM_CH-1:0] sample_valid;
	logic [NUM_CH*SW-1:0] sample_data;
	logic [NUM_CH-1:0] beat_ready;
	logic [NUM_CH*BW-1:0] head_data;
	logic [NUM_CH-1:0] beat_pop;

	////////////////////////////////////////////////////////////
	// Filter and trigger
	////////////////////////////////////////////////////////////

	sample_front_end #(
		.NUM_CH (NUM_CH)
	) i_front_end (
		.avalon_clk            (avalon_clk),
		.rst_n                 (rst_n),
		.rx_data               (rx_data),
		.rx_datak              (rx_datak),
		.rx_syncstatus         (rx_syncstatus),
		.threshold             (threshold),
		.sample_valid          (sample_valid),
		.sample_data           (sample_data),
		.triggering_status     (triggering_status),
		.triggering_time_stamp (triggering_time_stamp)
	);

	// One reorder buffer per lane
	for (genvar c = 0; c < NUM_CH; c++) begin : g_buf
		channel_reorder_buffer #(
			.BURST_LEN  (BURST_LEN),
			.FIFO_DEPTH (FIFO_DEPTH)
		) i_buf (
			.avalon_clk   (avalon_clk),
			.rst_n        (rst_n),
			.sample_valid (sample_valid[c]),
			.sample_data  (sample_data[c*SW +: SW]),
			.beat_pop     (beat_pop[c]),
			.beat_ready   (beat_ready[c]),
			.head_data    (head_data[c*BW +: BW])
		);
	end

	////////////////////////////////////////////////////////////
	// Burst writer
	////////////////////////////////////////////////////////////

	dram_write_scheduler #(
		.NUM_CH              (NUM_CH),
		.BURST_LEN           (BURST_LEN),
		.REGION_BITS         (REGION_BITS),
		.POST_TRIGGER_BURSTS (POST_TRIGGER_BURSTS)
	) i_scheduler (
		.avalon_clk         (avalon_clk),
		.rst_n              (rst_n),
		.beat_ready         (beat_ready),
		.head_data          (head_data),
		.beat_pop           (beat_pop),
		.triggering_status  (triggering_status),
		.dram_waitrequest_n (dram_waitrequest_n),
		.dram_write         (dram_write),
		.dram_burst_begin   (dram_burst_begin),
		.dram_burst_count   (dram_burst_count),
		.dram_address       (dram_address),
		.dram_writedata     (dram_writedata),
		.capture_mask       (capture_mask)
	);

endmodule

/* tb_daq_capture.sv */
`timescale 1ns/1ns

module tb_daq_capture;

	localparam int NUM_CH = 4;
	localparam int BURST_LEN = 4;
	localparam int FIFO_DEPTH = 8;
	localparam int REGION_BITS = 20;
	localparam int POST_TRIGGER_BURSTS = 2;

	localparam int SW = daq_capture_pkg::SAMPLE_W;
	localparam int BW = daq_capture_pkg::BEAT_W;
	localparam int AW = daq_capture_pkg::ADDR_W;
	localparam int TS_W = daq_capture_pkg::TS_W;

	localparam int SAMPLES_PER_LANE = 48 * daq_capture_pkg::WORDS_PER_BEAT;   // 48 beats
	localparam int TRIG_LANE = 2;
	localparam int TRIG_SAMPLE = 320;
	localparam logic [SW-1:0] THRESHOLD = 16'hE000;
	localparam logic [SW-1:0] TRIG_VALUE = 16'hF000;
	localparam int TIMEOUT_CYCLES = 4 * (NUM_CH * SAMPLES_PER_LANE * 4) + 2000;
	localparam logic [31:0] LFSR_SEED = 32'd98082;
	localparam logic [31:0] LFSR_TAPS = 32'h80200003;

	logic avalon_clk;
	logic rst_n;
	logic [NUM_CH*SW-1:0] rx_data;
	logic [NUM_CH-1:0] rx_datak;
	logic [NUM_CH-1:0] rx_syncstatus;
	logic [SW-1:0] threshold;
	logic dram_waitrequest_n;
	logic dram_write;
	logic dram_burst_begin;
	logic [daq_capture_pkg::BURST_W-1:0] dram_burst_count;
	logic [AW-1:0] dram_address;
	logic [BW-1:0] dram_writedata;
	logic triggering_status;
	logic [TS_W-1:0] triggering_time_stamp;
	logic [NUM_CH-1:0] capture_mask;

	logic [31:0] lfsr;
	int sent [NUM_CH];            // Samples driven per lane
	int cycle_cnt;

	// Monitor state
	int edge_cnt;                 // Rising edges since reset release
	int beat_idx [NUM_CH];        // Beats seen per channel
	int post_cnt [NUM_CH];        // Post-trigger bursts per channel
	int beat_in_burst;
	int burst_ch;
	logic [AW-1:0] burst_addr;
	logic burst_post;
	logic [NUM_CH-1:0] mask_due;
	logic trig_expect;
	logic [TS_W-1:0] exp_ts;
	logic prev_stall;             // Beat held under wait last cycle
	logic prev_begin;
	logic [AW-1:0] prev_addr;
	logic [BW-1:0] prev_data;

	daq_capture_top #(
		.NUM_CH              (NUM_CH),
		.BURST_LEN           (BURST_LEN),
		.FIFO_DEPTH          (FIFO_DEPTH),
		.REGION_BITS         (REGION_BITS),
		.POST_TRIGGER_BURSTS (POST_TRIGGER_BURSTS)
	) i_dut (
		.avalon_clk            (avalon_clk),
		.rst_n                 (rst_n),
		.rx_data               (rx_data),
		.rx_datak              (rx_datak),
		.rx_syncstatus         (rx_syncstatus),
		.threshold             (threshold),
		.dram_waitrequest_n    (dram_waitrequest_n),
		.dram_write            (dram_write),
		.dram_burst_begin      (dram_burst_begin),
		.dram_burst_count      (dram_burst_count),
		.dram_address          (dram_address),
		.dram_writedata        (dram_writedata),
		.triggering_status     (triggering_status),
		.triggering_time_stamp (triggering_time_stamp),
		.capture_mask          (capture_mask)
	);

	initial avalon_clk = 1'b0;
	always #50 avalon_clk = ~avalon_clk;   // 100 ns period

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0]) n = n ^ LFSR_TAPS;   // Galois feedback
		return n;
	endfunction

	task automatic take_bit(output logic b);
		lfsr = lfsr_next(lfsr);
		b = lfsr[0];
	endtask

	// Sample n of lane c with one spike on the trigger lane
	function automatic logic [SW-1:0] sample_value(input int c, input int n);
		if (c == TRIG_LANE && n == TRIG_SAMPLE) return TRIG_VALUE;
		return SW'(c * 4096 + (n % 4096));
	endfunction

	function automatic logic [BW-1:0] expected_beat(input int c, input int k);
		logic [BW-1:0] beat;
		for (int s = 0; s < daq_capture_pkg::WORDS_PER_BEAT; s++)
			beat[s*SW +: SW] = sample_value(c, k * daq_capture_pkg::WORDS_PER_BEAT + s);
		return beat;   // First sample lowest
	endfunction

	// Channel region base plus beats already written
	function automatic logic [AW-1:0] expected_address(input int c, input int k);
		logic [AW-1:0] base;
		base = AW'(c) << REGION_BITS;
		return base + AW'(k % (1 << REGION_BITS));
	endfunction

	function automatic logic word_hits(input logic [SW-1:0] data, input logic datak,
			input logic sync);
		return sync && !datak && (data > threshold);
	endfunction

	task automatic check_equal(input string name, input logic [BW-1:0] expected,
			input logic [BW-1:0] actual);
		if (expected !== actual) begin
			$display("mismatch %s expected %0h actual %0h", name, expected, actual);
			$display("Test failed");
			$fatal(1, "stopped at first error");
		end
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	task automatic drive_cycle();
		logic b0;
		logic b1;
		logic b2;
		logic w;
		for (int c = 0; c < NUM_CH; c++) begin
			take_bit(b0);
			take_bit(b1);
			if (b0 && b1 && sent[c] < SAMPLES_PER_LANE) begin   // About one cycle in four
				rx_data[c*SW +: SW] = sample_value(c, sent[c]);
				rx_datak[c] = 1'b0;
				rx_syncstatus[c] = 1'b1;
				sent[c]++;
			end else begin
				take_bit(b2);
				rx_data[c*SW +: SW] = 16'hFFFF;   // Over threshold, must be dropped
				rx_datak[c] = b2;                  // K word, or lane out of sync
				rx_syncstatus[c] = b2;
			end
		end
		take_bit(w);
		dram_waitrequest_n = w;
	endtask

	function automatic logic all_sent();
		for (int c = 0; c < NUM_CH; c++)
			if (sent[c] < SAMPLES_PER_LANE) return 1'b0;
		return 1'b1;
	endfunction

	initial begin
		lfsr = LFSR_SEED;
		rst_n = 1'b0;
		rx_data = '0;
		rx_datak = '0;
		rx_syncstatus = '0;
		threshold = THRESHOLD;
		dram_waitrequest_n = 1'b1;
		for (int c = 0; c < NUM_CH; c++) sent[c] = 0;
		repeat (10) @(posedge avalon_clk);
		#5 rst_n = 1'b1;
		while (!all_sent()) begin
			@(posedge avalon_clk);
			#5 drive_cycle();
		end
		// Drain until every channel has stopped
		while (capture_mask != {NUM_CH{1'b1}}) begin
			@(posedge avalon_clk);
			#5 drive_cycle();
		end
		repeat (100) begin   // Masked channels stay silent
			@(posedge avalon_clk);
			#5 drive_cycle();
		end
		check_equal("trigger seen", BW'(1'b1), BW'(triggering_status));
		check_equal("burst closed", BW'(0), BW'(beat_in_burst));
		for (int c = 0; c < NUM_CH; c++)
			check_equal($sformatf("post-trigger bursts ch %0d", c),
				BW'(POST_TRIGGER_BURSTS), BW'(post_cnt[c]));
		$display("Test completed successfully");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Memory model and monitor
	////////////////////////////////////////////////////////////

	// Beat taken at the coming edge
	task automatic record_beat();
		int ch;
		ch = int'(dram_address >> REGION_BITS);
		if (beat_in_burst == 0) begin
			check_equal("burst begin on first beat", BW'(1'b1), BW'(dram_burst_begin));
			check_equal("burst count", BW'(BURST_LEN), BW'(dram_burst_count));
			check_equal("burst channel in range", BW'(1'b1), BW'(ch < NUM_CH));
			check_equal($sformatf("write after mask ch %0d", ch), BW'(0), BW'(capture_mask[ch]));
			check_equal($sformatf("burst address ch %0d", ch),
				BW'(expected_address(ch, beat_idx[ch])), BW'(dram_address));
			burst_ch = ch;
			burst_addr = dram_address;
			burst_post = trig_expect;   // Trigger already high in begin cycle
		end else begin
			check_equal("burst begin inside burst", BW'(0), BW'(dram_burst_begin));
			check_equal("burst count inside burst", BW'(0), BW'(dram_burst_count));
			check_equal("address inside burst", BW'(burst_addr), BW'(dram_address));
		end
		check_equal($sformatf("beat data ch %0d beat %0d", burst_ch, beat_idx[burst_ch]),
			expected_beat(burst_ch, beat_idx[burst_ch]), dram_writedata);
		beat_idx[burst_ch]++;
		beat_in_burst++;
		if (beat_in_burst == BURST_LEN) begin
			beat_in_burst = 0;
			if (burst_post) begin
				post_cnt[burst_ch]++;
				if (post_cnt[burst_ch] == POST_TRIGGER_BURSTS) mask_due[burst_ch] = 1'b1;
			end
		end
	endtask

	// Mid-cycle sample with inputs and outputs settled
	always @(negedge avalon_clk) begin
		if (!rst_n) begin
			edge_cnt = 0;
			beat_in_burst = 0;
			burst_ch = 0;
			burst_addr = '0;
			burst_post = 1'b0;
			mask_due = '0;
			trig_expect = 1'b0;
			exp_ts = '0;
			prev_stall = 1'b0;
			for (int c = 0; c < NUM_CH; c++) begin
				beat_idx[c] = 0;
				post_cnt[c] = 0;
			end
		end else begin
			check_equal("trigger status", BW'(trig_expect), BW'(triggering_status));
			if (trig_expect)
				check_equal("trigger time stamp", BW'(exp_ts), BW'(triggering_time_stamp));
			check_equal("capture mask", BW'(mask_due), BW'(capture_mask));
			if (prev_stall) begin   // Nothing taken at the last edge
				check_equal("write held", BW'(1'b1), BW'(dram_write));
				check_equal("address held", BW'(prev_addr), BW'(dram_address));
				check_equal("data held", prev_data, dram_writedata);
				check_equal("begin held", BW'(prev_begin), BW'(dram_burst_begin));
			end
			prev_stall = dram_write && !dram_waitrequest_n;
			prev_addr = dram_address;
			prev_data = dram_writedata;
			prev_begin = dram_burst_begin;
			if (dram_write && dram_waitrequest_n) record_beat();
			// First accepted word over threshold
			for (int c = 0; c < NUM_CH; c++) begin
				if (!trig_expect && word_hits(rx_data[c*SW +: SW], rx_datak[c],
						rx_syncstatus[c])) begin
					trig_expect = 1'b1;
					exp_ts = TS_W'(edge_cnt);
				end
			end
			edge_cnt++;
		end
	end

	// Run limit
	initial cycle_cnt = 0;
	always @(posedge avalon_clk) begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, capture never stopped on all channels",
				cycle_cnt);
			$display("Test failed");
			$fatal(1, "timeout");
		end
	end

endmodule

/* daq_capture.f */
daq_capture_pkg.sv
sample_front_end.sv
channel_reorder_buffer.sv
dram_write_scheduler.sv
daq_capture_top.sv
tb_daq_capture.sv

/* Makefile */
VERILATOR ?= verilator
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS ?= --binary --timing --assert -j 0
TOP ?= tb_daq_capture
FILELIST ?= daq_capture.f
OBJ_DIR ?= obj_dir
PASS_MSG := Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Pass only if the pass message shows up in the run output
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
